// ==== source/cpu_types_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu types
// processor-wide word type and word constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpu_types_pkg;

  // width of one data or address word
  parameter int WORD_W = 32;

  // one machine word
  // used for data, addresses and loaded values alike
  typedef logic [WORD_W-1:0] word_t;

  // all-zero word
  // idle value on the load buses
  parameter word_t WORD_ZERO = '0;

endpackage

// ==== source/mem_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory bus types
// ram state and the cache-side / ram-side request structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_bus_pkg;
  import cpu_types_pkg::*;

  // condition reported by the ram every cycle
  //   FREE    no enable is high
  //   BUSY    a command is counting down its latency
  //   ACCESS  this cycle completes the command
  typedef enum logic [1:0] {
    FREE   = 2'd0,
    BUSY   = 2'd1,
    ACCESS = 2'd2
  } ramstate_t;

  // cache side request into the controller
  // enables are levels held until the matching wait drops
  // dren and dwen are never high together
  typedef struct packed {
    logic  iren;
    logic  dren;
    logic  dwen;
    word_t iaddr;
    word_t daddr;
    word_t dstore;
  } cache_req_t;

  // command from the controller to the ram
  // only one port owns these fields at a time
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } ram_req_t;

endpackage

// ==== source/ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word ram
// word-addressed storage with a parameterized access latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ram
  import cpu_types_pkg::*, mem_bus_pkg::*;
#(
  parameter int RAM_DEPTH = 64,
  parameter int RAM_LAT   = 2
) (
  input  logic      CLK,
  input  logic      arst_n,
  input  ram_req_t  rreq,
  output ramstate_t ramstate,
  output word_t     ramload
);

  // index bits, addresses alias modulo RAM_DEPTH
  localparam int ADDR_W = $clog2(RAM_DEPTH);
  // counter must hold the value RAM_LAT itself
  localparam int CNT_W  = $clog2(RAM_LAT + 1);

  // parameter sanity at elaboration
  if (RAM_LAT < 1) begin : g_bad_lat
    $error("RAM_LAT must be at least 1");
  end
  if (RAM_DEPTH < 2 || (RAM_DEPTH & (RAM_DEPTH - 1)) != 0) begin : g_bad_depth
    $error("RAM_DEPTH must be a power of two, at least 2");
  end

  word_t mem [RAM_DEPTH];

  ram_req_t          prev_q;
  logic              seen_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [CNT_W-1:0]  cnt_eff;
  logic              active;
  logic              same_cmd;
  logic [ADDR_W-1:0] idx;

  assign active = rreq.ren | rreq.wen;
  assign idx    = rreq.addr[ADDR_W-1:0];

  // same command as last cycle, store data is not part of the compare
  assign same_cmd = seen_q
                  && rreq.ren  == prev_q.ren
                  && rreq.wen  == prev_q.wen
                  && rreq.addr == prev_q.addr;

  // a changed command counts from zero in the cycle it shows up
  assign cnt_eff = same_cmd ? cnt_q : '0;

  always_comb begin
    if (!active) begin
      ramstate = FREE;
    end else if (cnt_eff == CNT_W'(RAM_LAT)) begin
      ramstate = ACCESS;
    end else begin
      ramstate = BUSY;
    end
  end

  // latency tracking
  // after ACCESS the count clears and the next command starts fresh
  // even when it matches the one just served
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      prev_q <= '0;
      seen_q <= 1'b0;
      cnt_q  <= '0;
    end else if (ramstate == ACCESS) begin
      seen_q <= 1'b0;
      cnt_q  <= '0;
    end else if (active) begin
      prev_q <= rreq;
      seen_q <= 1'b1;
      cnt_q  <= cnt_eff + CNT_W'(1);
    end else begin
      seen_q <= 1'b0;
      cnt_q  <= '0;
    end
  end

  // write commits at the edge closing the ACCESS cycle
  always_ff @(posedge CLK) begin
    if (ramstate == ACCESS && rreq.wen) begin
      mem[idx] <= rreq.store;
    end
  end

  // combinational read, valid only in the ACCESS cycle
  assign ramload = (ramstate == ACCESS) ? mem[idx] : WORD_ZERO;

  // an ACCESS closes a command already present RAM_LAT cycles before
  assert property (@(posedge CLK) disable iff (!arst_n)
    (ramstate == ACCESS) |-> active
      && $past(rreq.ren, RAM_LAT) == rreq.ren
      && $past(rreq.wen, RAM_LAT) == rreq.wen
      && $past(rreq.addr, RAM_LAT) == rreq.addr)
    else $error("ram ACCESS without a command held for RAM_LAT cycles");

endmodule

// ==== source/memory_control.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory controller
// arbitrates instruction and data ports onto one ram
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module memory_control
  import cpu_types_pkg::*, mem_bus_pkg::*;
(
  input  logic       CLK,
  input  logic       arst_n,
  input  cache_req_t creq,
  input  ramstate_t  ramstate,
  input  word_t      ramload,
  output logic       iwait,
  output logic       dwait,
  output word_t      iload,
  output word_t      dload,
  output ram_req_t   rreq
);

  // which port currently drives the ram
  typedef enum logic [1:0] {
    OWN_NONE  = 2'd0,
    OWN_INSTR = 2'd1,
    OWN_DATA  = 2'd2
  } owner_t;

  owner_t owner_q;
  owner_t owner_sel;
  owner_t owner_d;

  logic ireq;
  logic dreq;
  logic done;

  // a port is requesting when any of its enables is up
  assign ireq = creq.iren;
  assign dreq = creq.dren | creq.dwen;

  // ram finishes the current command this cycle
  assign done = (ramstate == ACCESS);

  // owner selection
  // a held owner keeps the ram until ACCESS
  // with no owner the data port wins over fetch
  always_comb begin
    owner_sel = owner_q;
    if (owner_q == OWN_NONE) begin
      if (dreq) begin
        owner_sel = OWN_DATA;
      end else if (ireq) begin
        owner_sel = OWN_INSTR;
      end
    end
  end

  // release on completion
  // FREE means the owner's enables went away, so let go as well
  always_comb begin
    owner_d = owner_sel;
    if (done || ramstate == FREE) begin
      owner_d = OWN_NONE;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      owner_q <= OWN_NONE;
    end else begin
      owner_q <= owner_d;
    end
  end

  // steer the owning port onto the ram command
  always_comb begin
    rreq = '0;
    case (owner_sel)
      OWN_DATA: begin
        rreq.ren   = creq.dren;
        rreq.wen   = creq.dwen;
        rreq.addr  = creq.daddr;
        rreq.store = creq.dstore;
      end
      OWN_INSTR: begin
        // fetch never writes
        rreq.ren   = creq.iren;
        rreq.addr  = creq.iaddr;
      end
      default: begin
        rreq = '0;
      end
    endcase
  end

  // wait stays high for a requesting port until its own access completes
  // the port that is not the owner keeps waiting
  assign iwait = ireq & ~(done & (owner_sel == OWN_INSTR));
  assign dwait = dreq & ~(done & (owner_sel == OWN_DATA));

  // loaded word is only shown to the port that owns the completing access
  assign iload = (done && owner_sel == OWN_INSTR) ? ramload : WORD_ZERO;
  assign dload = (done && owner_sel == OWN_DATA) ? ramload : WORD_ZERO;

  // a completing ram access releases exactly one requesting port
  // never both, and never none
  assert property (@(posedge CLK) disable iff (!arst_n)
    done |-> ((ireq && !iwait) != (dreq && !dwait)))
    else $error("completed access did not release exactly one port");

  // the requester must never ask for a read and a write at once
  assert property (@(posedge CLK) disable iff (!arst_n)
    !(rreq.ren && rreq.wen))
    else $error("ram read and write enables high together");

endmodule

// ==== source/memory_system.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory system top
// joins the memory controller and the ram
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module memory_system
  import cpu_types_pkg::*, mem_bus_pkg::*;
#(
  parameter int RAM_DEPTH = 64,
  parameter int RAM_LAT   = 2
) (
  input  logic       CLK,
  input  logic       arst_n,
  input  cache_req_t creq,
  output logic       iwait,
  output logic       dwait,
  output word_t      iload,
  output word_t      dload
);

  // controller to ram command
  ram_req_t  rreq;
  // ram back to controller
  ramstate_t ramstate;
  word_t     ramload;

  // arbiter between fetch and data ports
  memory_control u_memory_control (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .creq     (creq),
    .ramstate (ramstate),
    .ramload  (ramload),
    .iwait    (iwait),
    .dwait    (dwait),
    .iload    (iload),
    .dload    (dload),
    .rreq     (rreq)
  );

  // storage, sized and timed from the top
  ram #(
    .RAM_DEPTH (RAM_DEPTH),
    .RAM_LAT   (RAM_LAT)
  ) u_ram (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .rreq     (rreq),
    .ramstate (ramstate),
    .ramload  (ramload)
  );

endmodule

// ==== testbench/memory_system_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory system testbench
// directed checks of writes, reads, arbitration and latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module memory_system_tb
  import cpu_types_pkg::*, mem_bus_pkg::*;
();

  localparam int RAM_DEPTH = 64;
  localparam int RAM_LAT   = 2;
  localparam int RST_CYC   = 8;
  localparam int N_WORDS   = 16;
  localparam logic [31:0] SEED = 32'h2d4b;

  // accesses over all tests
  // write/read-back, fetch, latency, priority, no preemption, aliasing
  localparam int N_ACCESS    = 2 * N_WORDS + N_WORDS + 2 + 2 + 3 + 2;
  localparam int TIMEOUT_CYC = N_ACCESS * (2 * RAM_LAT + 4) + 100;

  logic       CLK;
  logic       arst_n;
  cache_req_t creq;
  logic       iwait;
  logic       dwait;
  word_t      iload;
  word_t      dload;

  // reference contents, indexed modulo RAM_DEPTH
  word_t model [RAM_DEPTH];
  // addresses written by the first test
  word_t addr_list [N_WORDS];
  int    err_cnt;

  memory_system #(
    .RAM_DEPTH (RAM_DEPTH),
    .RAM_LAT   (RAM_LAT)
  ) u_memory_system (
    .CLK    (CLK),
    .arst_n (arst_n),
    .creq   (creq),
    .iwait  (iwait),
    .dwait  (dwait),
    .iload  (iload),
    .dload  (dload)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // addresses alias modulo the depth
  function automatic int model_index(input word_t addr);
    return int'(addr % RAM_DEPTH);
  endfunction

  // wait level of the chosen port
  function automatic logic port_wait(input logic instr);
    return instr ? iwait : dwait;
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // one access on an idle ram
  // request held until its wait is low, dropped at that same edge
  task automatic run_access(input logic instr, input logic write, input word_t addr,
                            input word_t data, output word_t load);
    int   edges;
    logic own_wait;
    logic other_wait;
    @(posedge CLK);
    if (instr) begin
      creq.iren  <= 1'b1;
      creq.iaddr <= addr;
    end else begin
      creq.dren   <= ~write;
      creq.dwen   <= write;
      creq.daddr  <= addr;
      creq.dstore <= data;
    end
    edges    = 0;
    own_wait = 1'b1;
    while (own_wait) begin
      @(posedge CLK);
      edges++;
      own_wait   = port_wait(instr);
      other_wait = port_wait(~instr);
      // idle port never waits
      check_value(instr ? "dwait" : "iwait", word_t'(other_wait), WORD_ZERO);
    end
    load = instr ? iload : dload;
    // drive edge, then RAM_LAT edges after the first edge that sees it
    check_value("wait latency edges", word_t'(edges), word_t'(RAM_LAT + 1));
    if (instr) begin
      creq.iren <= 1'b0;
    end else begin
      creq.dren <= 1'b0;
      creq.dwen <= 1'b0;
    end
  endtask

  task automatic write_data(input word_t addr, input word_t data);
    word_t load;
    run_access(1'b0, 1'b1, addr, data, load);
    model[model_index(addr)] = data;
  endtask

  task automatic read_data(input word_t addr, output word_t load);
    run_access(1'b0, 1'b0, addr, WORD_ZERO, load);
    check_value("dload", load, model[model_index(addr)]);
  endtask

  task automatic read_instr(input word_t addr);
    word_t load;
    run_access(1'b1, 1'b0, addr, WORD_ZERO, load);
    check_value("iload", load, model[model_index(addr)]);
  endtask

  task automatic write_read_back();
    word_t load;
    for (int i = 0; i < N_WORDS; i++) begin
      addr_list[i] = word_t'($urandom);
      write_data(addr_list[i], word_t'($urandom));
    end
    for (int i = 0; i < N_WORDS; i++) begin
      read_data(addr_list[i], load);
    end
  endtask

  // dwait low throughout is checked inside each access
  task automatic fetch_from_memory();
    for (int i = 0; i < N_WORDS; i++) begin
      read_instr(addr_list[i]);
    end
  endtask

  // wait low for one cycle only, a held request starts over
  task automatic check_latency(input logic instr, input word_t addr);
    word_t exp;
    exp = model[model_index(addr)];
    @(posedge CLK);
    if (instr) begin
      creq.iren  <= 1'b1;
      creq.iaddr <= addr;
    end else begin
      creq.dren  <= 1'b1;
      creq.daddr <= addr;
    end
    for (int k = 1; k <= RAM_LAT; k++) begin
      @(posedge CLK);
      check_value("wait before access", word_t'(port_wait(instr)), word_t'(1));
    end
    @(posedge CLK);
    check_value("wait at access", word_t'(port_wait(instr)), WORD_ZERO);
    check_value(instr ? "iload" : "dload", instr ? iload : dload, exp);
    @(posedge CLK);
    check_value("wait after access", word_t'(port_wait(instr)), word_t'(1));
    creq.iren <= 1'b0;
    creq.dren <= 1'b0;
    @(posedge CLK);
  endtask

  task automatic access_latency();
    check_latency(1'b0, addr_list[0]);
    check_latency(1'b1, addr_list[0]);
  endtask

  // both ports raised at one edge, data served first
  task automatic data_priority();
    int n;
    int d_at;
    int i_at;
    @(posedge CLK);
    creq.iren  <= 1'b1;
    creq.iaddr <= addr_list[1];
    creq.dren  <= 1'b1;
    creq.daddr <= addr_list[2];
    n    = 0;
    d_at = 0;
    i_at = 0;
    while (d_at == 0 || i_at == 0) begin
      @(posedge CLK);
      n++;
      if (d_at == 0 && !dwait) begin
        d_at = n;
        check_value("iwait at data access", word_t'(iwait), word_t'(1));
        check_value("dload", dload, model[model_index(addr_list[2])]);
        creq.dren <= 1'b0;
      end
      if (i_at == 0 && !iwait) begin
        i_at = n;
        check_value("iload", iload, model[model_index(addr_list[1])]);
        creq.iren <= 1'b0;
      end
    end
    check_value("dwait drop edge", word_t'(d_at), word_t'(RAM_LAT + 1));
    // fetch command first seen at the edge after the data access closes
    check_value("iwait drop edge", word_t'(i_at), word_t'(d_at + RAM_LAT + 1));
  endtask

  // write arriving during a fetch waits for it
  task automatic fetch_not_preempted();
    word_t addr;
    word_t old_word;
    word_t new_word;
    word_t load;
    logic  done;
    addr     = addr_list[3];
    old_word = model[model_index(addr)];
    new_word = ~old_word ^ word_t'($urandom);
    @(posedge CLK);
    creq.iren  <= 1'b1;
    creq.iaddr <= addr;
    @(posedge CLK);
    check_value("iwait", word_t'(iwait), word_t'(1));
    creq.dwen   <= 1'b1;
    creq.daddr  <= addr;
    creq.dstore <= new_word;
    done = 1'b0;
    while (!done) begin
      @(posedge CLK);
      done = ~iwait;
    end
    check_value("dwait at fetch access", word_t'(dwait), word_t'(1));
    check_value("iload", iload, old_word);
    creq.iren <= 1'b0;
    done = 1'b0;
    while (!done) begin
      @(posedge CLK);
      done = ~dwait;
    end
    creq.dwen <= 1'b0;
    model[model_index(addr)] = new_word;
    read_data(addr, load);
    check_value("dload new word", load, new_word);
  endtask

  task automatic address_aliasing();
    word_t base;
    word_t data;
    word_t load;
    base = word_t'($urandom) & word_t'(RAM_DEPTH - 1);
    data = word_t'($urandom);
    write_data(base + word_t'(RAM_DEPTH), data);
    read_data(base, load);
    check_value("dload alias", load, data);
  endtask

  initial begin
    err_cnt = 0;
    arst_n  = 1'b0;
    creq    = '0;
    void'($urandom(SEED));
    repeat (RST_CYC) @(posedge CLK);
    arst_n <= 1'b1;
    @(posedge CLK);
    write_read_back();
    fetch_from_memory();
    access_latency();
    data_priority();
    fetch_not_preempted();
    address_aliasing();
    @(posedge CLK);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // bound on run length from the number of accesses
  initial begin
    repeat (TIMEOUT_CYC) @(posedge CLK);
    $display("watchdog timeout: tests did not finish within %0d cycles", TIMEOUT_CYC);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

endmodule

// ==== list.f ====
source/cpu_types_pkg.sv
source/mem_bus_pkg.sv
source/ram.sv
source/memory_control.sv
source/memory_system.sv
testbench/memory_system_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory system testbench with verilator
# exit status is 0 only when the pass message shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module memory_system_tb -f list.f -o memory_system_sim \
  || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/memory_system_sim 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
